// File: Bender.yml
package:
  name: aes_enc

export_include_dirs:
  - common

sources:
  - files:
      - common/aes_pkg.sv
      - design/aes_in_fifo.sv
      - round/aes_sub_bytes.sv
      - round/aes_shift_mix.sv
      - design/aes_key_rom.sv
      - design/aes_enc_ctrl.sv
      - design/aes_enc_top.sv
  - target: test
    files:
      - test/tb_aes_enc.sv

// File: aes_enc.f
+incdir+common
common/aes_pkg.sv
design/aes_in_fifo.sv
round/aes_sub_bytes.sv
round/aes_shift_mix.sv
design/aes_key_rom.sv
design/aes_enc_ctrl.sv
design/aes_enc_top.sv
test/tb_aes_enc.sv

// File: common/aes_config.svh
/*
 * core sizing macros
 * round count, input buffer depth, initial output credits
 */
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// aes-256 only
`define AES_ROUNDS      14
// buffer slots, also the host's starting input credits
`define IN_FIFO_DEPTH   4
// sink slots granted to the core after reset
`define OUT_CREDITS     2

`endif

// File: common/aes_pkg.sv
/*
 * shared types of the aes-256 core
 * state block, control flags, input word views, port structs
 */
package aes_pkg;

    // 16 bytes, byte 0 is the msb, column-major as in fips-197
    typedef logic [0:15][7:0] aes_state_t;

    // control flags, only enable is live
    typedef struct packed {
        logic [6:0] reserved;
        logic       enable;
    } aes_ctrl_t;

    // control view of an input word, flags in the low byte
    typedef struct packed {
        logic [119:0] unused;
        aes_ctrl_t    flags;
    } aes_ctrl_view_t;

    // one write word, read as a block or as flags depending on sel_data
    typedef union packed {
        aes_state_t     block;
        aes_ctrl_view_t ctrl;
    } aes_in_word_u;

    // host write port
    typedef struct packed {
        logic         valid;
        logic         sel_data;
        aes_in_word_u word;
    } aes_in_t;

    // ciphertext port
    typedef struct packed {
        logic       valid;
        aes_state_t data;
    } aes_out_t;

endpackage

// File: design/aes_enc_ctrl.sv
/*
 * encryption control
 * flag register, round counter, state register with AddRoundKey,
 * output credit counter
 */
`timescale 1ns/10ps
`include "aes_config.svh"

module aes_enc_ctrl import aes_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  aes_in_t    in_req,
    input  logic       not_empty,
    input  aes_state_t head,
    output logic       pop,
    output aes_state_t state_q,
    input  aes_state_t mixed,
    output logic [3:0] round,
    input  aes_state_t round_key,
    output logic       last_round,
    output aes_out_t   out_resp,
    input  logic       out_credit
);

    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

    aes_ctrl_t        ctrl_q;
    logic             busy;
    logic             done;
    logic [CRD_W-1:0] credit_q;
    logic             out_fire;

    // start a block only when idle and enabled
    assign pop        = !busy && ctrl_q.enable && not_empty;
    assign last_round = (round == 4'(`AES_ROUNDS));

    // result leaves with the first available credit
    assign out_fire      = done && (credit_q != '0);
    assign out_resp.valid = out_fire;
    assign out_resp.data  = state_q;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            ctrl_q   <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            round    <= '0;
            credit_q <= CRD_W'(`OUT_CREDITS);
        end
        else
        begin
            // flag words read through the control view
            if (in_req.valid && !in_req.sel_data)
                ctrl_q <= in_req.word.ctrl.flags;
            if (pop)
            begin
                busy  <= 1'b1;
                round <= 4'd1;
            end
            else if (busy && !done)
            begin
                // final round finishes the block
                if (last_round)
                begin
                    done  <= 1'b1;
                    round <= '0;
                end
                else
                    round <= round + 1'b1;
            end
            else if (out_fire)
            begin
                busy <= 1'b0;
                done <= 1'b0;
            end
            // send and return may land together
            if (out_fire && !out_credit)
                credit_q <= credit_q - 1'b1;
            else if (out_credit && !out_fire)
                credit_q <= credit_q + 1'b1;
        end
    end

    // AddRoundKey, key 0 on load, mixed state afterwards
    always_ff @(posedge clk)
    begin
        if (pop)
            state_q <= head ^ round_key;
        else if (busy && !done)
            state_q <= mixed ^ round_key;
    end

    // sink returned more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
        credit_q <= CRD_W'(`OUT_CREDITS));

    a_round_bound: assert property (@(posedge clk) disable iff (!resetn)
        round <= 4'(`AES_ROUNDS));

endmodule

// File: design/aes_enc_top.sv
/*
 * aes-256 encryption core top
 * input buffer, control, round datapath and key table
 */
`timescale 1ns/10ps

module aes_enc_top import aes_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  aes_in_t  in_req,
    output logic     in_credit,
    output aes_out_t out_resp,
    input  logic     out_credit
);

    aes_state_t head;
    logic       not_empty;
    logic       pop;
    aes_state_t state_q;
    aes_state_t sub_out;
    aes_state_t mixed;
    logic [3:0] round;
    aes_state_t round_key;
    logic       last_round;

    // plaintext buffer
    aes_in_fifo aes_in_fifo_i (
        .clk       (clk),
        .resetn    (resetn),
        .in_req    (in_req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .in_credit (in_credit)
    );

    // sequencing and AddRoundKey
    aes_enc_ctrl aes_enc_ctrl_i (
        .clk        (clk),
        .resetn     (resetn),
        .in_req     (in_req),
        .not_empty  (not_empty),
        .head       (head),
        .pop        (pop),
        .state_q    (state_q),
        .mixed      (mixed),
        .round      (round),
        .round_key  (round_key),
        .last_round (last_round),
        .out_resp   (out_resp),
        .out_credit (out_credit)
    );

    // round datapath
    aes_sub_bytes aes_sub_bytes_i (
        .state_in  (state_q),
        .state_out (sub_out)
    );

    aes_shift_mix aes_shift_mix_i (
        .state_in   (sub_out),
        .last_round (last_round),
        .state_out  (mixed)
    );

    aes_key_rom aes_key_rom_i (
        .round     (round),
        .round_key (round_key)
    );

endmodule

// File: design/aes_in_fifo.sv
/*
 * plaintext input buffer
 * circular store of blocks, returns one host credit per pop
 */
`timescale 1ns/10ps
`include "aes_config.svh"

module aes_in_fifo import aes_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  aes_in_t    in_req,
    input  logic       pop,
    output aes_state_t head,
    output logic       not_empty,
    output logic       in_credit
);

    localparam int PTR_W = $clog2(`IN_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`IN_FIFO_DEPTH + 1);

    aes_state_t       mem [`IN_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr;

    // flag words never enter the buffer
    assign wr = in_req.valid && in_req.sel_data;

    // block storage
    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_ptr] <= in_req.word.block;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr)
                wr_ptr <= (wr_ptr == PTR_W'(`IN_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`IN_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous write and pop leaves count unchanged
            if (wr && !pop)
                count <= count + 1'b1;
            else if (pop && !wr)
                count <= count - 1'b1;
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);
    // a freed slot goes straight back to the host
    assign in_credit = pop;

    // host spent a credit it never had
    a_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
        wr |-> (count < CNT_W'(`IN_FIFO_DEPTH)));

    // control side must only pop a present block
    a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
        pop |-> not_empty);

endmodule

// File: design/aes_key_rom.sv
/*
 * round key table
 * 15 keys expanded from the fixed aes-256 example key 00..1f
 */
`timescale 1ns/10ps
`include "aes_config.svh"

module aes_key_rom import aes_pkg::*; (
    input  logic [3:0] round,
    output aes_state_t round_key
);

    // one entry per round, round 0 first
    localparam logic [0:`AES_ROUNDS][127:0] KEYS = {
        128'h000102030405060708090a0b0c0d0e0f,
        128'h101112131415161718191a1b1c1d1e1f,
        128'ha573c29fa176c498a97fce93a572c09c,
        128'h1651a8cd0244beda1a5da4c10640bade,
        128'hae87dff00ff11b68a68ed5fb03fc1567,
        128'h6de1f1486fa54f9275f8eb5373b8518d,
        128'hc656827fc9a799176f294cec6cd5598b,
        128'h3de23a75524775e727bf9eb45407cf39,
        128'h0bdc905fc27b0948ad5245a4c1871c2f,
        128'h45f5a66017b2d387300d4d33640a820a,
        128'h7ccff71cbeb4fe5413e6bbf0d261a7df,
        128'hf01afafee7a82979d7a5644ab3afe640,
        128'h2541fe719bf500258813bbd55a721c0a,
        128'h4e5a6699a9f24fe07e572baacdf8cdea,
        128'h24fc79ccbf0979e9371ac23c6d68de36
    };

    // index 15 is unused, give a clean zero
    assign round_key = (round <= 4'(`AES_ROUNDS)) ? aes_state_t'(KEYS[round]) : '0;

endmodule

// File: round/aes_shift_mix.sv
/*
 * ShiftRows then MixColumns
 * mix step bypassed in the final round
 */
`timescale 1ns/10ps

module aes_shift_mix import aes_pkg::*; (
    input  aes_state_t state_in,
    input  logic       last_round,
    output aes_state_t state_out
);

    aes_state_t shifted;
    aes_state_t mixed;

    // multiply by x in gf(2^8), poly 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte index is 4*col + row, row r rotates left by r
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[4*c + r] = state_in[4*((c + r) % 4) + r];
            end
        end
    end

    // fixed matrix 02 03 01 01, one column at a time
    always_comb
    begin
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = shifted[4*c];
            a1 = shifted[4*c + 1];
            a2 = shifted[4*c + 2];
            a3 = shifted[4*c + 3];
            // 3*a is xtime(a) ^ a
            mixed[4*c]     = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            mixed[4*c + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            mixed[4*c + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            mixed[4*c + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

    // round 14 has no MixColumns
    assign state_out = last_round ? shifted : mixed;

endmodule

// File: round/aes_sub_bytes.sv
/*
 * SubBytes step
 * forward s-box table, all 16 bytes in parallel
 */
`timescale 1ns/10ps

module aes_sub_bytes import aes_pkg::*; (
    input  aes_state_t state_in,
    output aes_state_t state_out
);

    // forward s-box, entry 0 at the top
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // byte-wise lookup
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            state_out[i] = SBOX[state_in[i]];
        end
    end

endmodule

// File: test/aes_enc_trace.txt
# columns: opcode operand
# C flags hex, D plaintext hex, E expected ciphertext hex, G credits returned, W idle cycles
# fips-197 aes-256 vector
C 01
E 8ea2b7ca516745bfeafc49904b496089
D 00112233445566778899aabbccddeeff
G 1
# enable clear, blocks must wait in the buffer
C 00
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
W 40
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
C 01
G 3
# output back-pressure, four queued and no credits returned
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
W 60
G 1
W 10
G 3
# burst fills the buffer while disabled, a fifth block waits for a credit
C 00
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
D 00112233445566778899aabbccddeeff
W 10
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
E 8ea2b7ca516745bfeafc49904b496089
C 01
E 8ea2b7ca516745bfeafc49904b496089
D 00112233445566778899aabbccddeeff
G 5
# reserved bits set with enable clear, block low byte ff reads like flags
C fe
D 00112233445566778899aabbccddeeff
W 40
E 8ea2b7ca516745bfeafc49904b496089
C 01
G 1

// File: test/tb_aes_enc.sv
/*
 * testbench for the aes-256 encryption core
 * trace-driven host with input credits, sink with output credits,
 * ciphertext checker and watchdog
 */
`timescale 1ns/10ps
`include "aes_config.svh"

module tb_aes_enc import aes_pkg::*; ();

    localparam string TRACE_FILE      = "test/aes_enc_trace.txt";
    localparam int    CYCLES_PER_LINE = 40;

    logic     clk;
    logic     resetn;
    aes_in_t  in_req;
    logic     in_credit;
    aes_out_t out_resp;
    logic     out_credit;

    // expected ciphertexts in arrival order
    logic [127:0] exp_q [$];
    integer       seed;
    int           mismatches;
    int           other_errors;
    int           in_credit_count;
    int           data_writes;
    int           received;
    int           returned;
    int           expected_total;
    int           limit_cycles;
    // flag register as the host has written it
    logic         enable_seen;

    aes_enc_top aes_enc_top_i (
        .clk        (clk),
        .resetn     (resetn),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_resp   (out_resp),
        .out_credit (out_credit)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        other_errors++;
    endtask

    // one word held for one cycle from a falling edge
    task automatic drive_word(input logic sel, input logic [127:0] value);
        in_req.valid    = 1'b1;
        in_req.sel_data = sel;
        in_req.word     = value;
        @(negedge clk);
        in_req = '0;
    endtask

    // host stalls here until it holds a credit
    task automatic write_block(input logic [127:0] value);
        while (`IN_FIFO_DEPTH + in_credit_count - data_writes <= 0)
            @(negedge clk);
        data_writes++;
        drive_word(1'b1, value);
    endtask

    // sink frees only slots that hold a ciphertext
    task automatic return_credits(input int n);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            while (received - returned <= 0)
                @(negedge clk);
            gap = $random(seed) & 3;
            repeat (gap) @(negedge clk);
            out_credit = 1'b1;
            returned++;
            @(negedge clk);
            out_credit = 1'b0;
        end
    endtask

    task automatic run_trace(input int fd);
        string        op;
        string        rest;
        logic [127:0] value;
        int           num;
        int           code;
        while ($fscanf(fd, "%s", op) == 1)
        begin
            code = 1;
            if (op.getc(0) == "#")
                code = ($fgets(rest, fd) != 0) ? 1 : 0;
            else if (op == "C" || op == "D" || op == "E")
            begin
                code = $fscanf(fd, "%h", value);
                if (op == "C")
                    drive_word(1'b0, {120'b0, value[7:0]});
                else if (op == "D")
                    write_block(value);
                else
                begin
                    exp_q.push_back(value);
                    expected_total++;
                end
            end
            else if (op == "G" || op == "W")
            begin
                code = $fscanf(fd, "%d", num);
                if (op == "G")
                    return_credits(num);
                else
                    repeat (num) @(negedge clk);
            end
            else
            begin
                report_error($sformatf("unknown trace opcode %s", op));
                code = ($fgets(rest, fd) != 0) ? 1 : 0;
            end
            if (code != 1)
                report_error($sformatf("trace line %s has no readable operand", op));
        end
    endtask

    // monitor on the rising edge
    always @(posedge clk)
    begin
        if (!resetn)
            enable_seen = 1'b0;
        else
        begin
            if (in_credit)
            begin
                in_credit_count++;
                if (!enable_seen)
                    report_error("input credit returned while enable is clear");
            end
            if (in_req.valid && !in_req.sel_data)
                enable_seen = in_req.word.ctrl.flags.enable;
            if (out_resp.valid)
            begin
                received++;
                if (received - returned > `OUT_CREDITS)
                    report_error("ciphertext sent while the sink had no free slot");
                if (exp_q.size() == 0)
                    report_error($sformatf("ciphertext %h arrived with nothing expected",
                                           out_resp.data));
                else
                    check_value("ciphertext", out_resp.data, exp_q.pop_front());
            end
        end
    end

    initial
    begin
        int    fd;
        int    lines;
        string line;
        clk             = 1'b0;
        resetn          = 1'b0;
        in_req          = '0;
        out_credit      = 1'b0;
        seed            = 32'hdf2b;
        enable_seen     = 1'b0;
        lines           = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
            report_error("cannot open the trace file test/aes_enc_trace.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
                lines++;
            $fclose(fd);
            limit_cycles = lines * CYCLES_PER_LINE;
            fd = $fopen(TRACE_FILE, "r");
            run_trace(fd);
            $fclose(fd);
            // drain the queue and watch for strays
            while (exp_q.size() != 0)
                @(negedge clk);
            repeat (40) @(negedge clk);
            check_value("in_credit pulses against data words", in_credit_count, data_writes);
            check_value("ciphertext count", received, expected_total);
        end
        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // run limit scales with the trace length
    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        report_error($sformatf("timeout after %0d cycles, the core stopped responding",
                               limit_cycles));
        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        $display("Test failures found");
        $finish;
    end

endmodule
